//--- list.f
+incdir+verilog
verilog/mulPkg.sv
verilog/ppGenStage.sv
verilog/wallaceReduceStage.sv
verilog/finalAddStage.sv
verilog/resultQueue.sv
verilog/mulTop.sv
dv/mulTb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mulTb -f list.f -o mulTbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mulTbSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Done: no errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

//--- dv/mulTb.sv
`include "mul_defines.svh"

module mulTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FreeReq   = 40;  // Requests sent while downstream credits flow freely
    localparam int NumReq    = 60;
    localparam int Depth     = `MUL_QUEUE_DEPTH;
    localparam int OutCrd    = `MUL_OUT_CREDITS;
    localparam int TimeoutNs = (NumReq * 40 + 16) * 20;

    logic            clk = 1'b0;
    logic            rst;
    mulPkg::mulReq_t req;
    logic            inCredit;
    mulPkg::mulRsp_t rsp;
    logic            outCredit = 1'b0;

    logic [`MUL_PROD_W-1:0] expProd [1 << `MUL_TAG_W];
    logic [`MUL_TAG_W-1:0]  sentTags [NumReq + 1];
    logic [`MUL_TAG_W-1:0]  nextTag = '0;
    logic [`MUL_OP_W-1:0]   lcgState = 32'd22;

    int sentCount   = 0;
    int rspIdx      = 0;
    int heldRsp     = 0;  // Responses seen while downstream credits are withheld
    int upCredits   = Depth;
    int downCredits = OutCrd;
    int errCount    = 0;

    bit giveCredits = 1'b1;
    bit holding     = 1'b0;
    bit holdEnd     = 1'b0;
    bit drained     = 1'b0;

    logic                   rspValid;
    logic [`MUL_TAG_W-1:0]  rspTag;
    logic [`MUL_PROD_W-1:0] rspProduct;
    logic [`MUL_TAG_W-1:0]  expTag;
    logic [`MUL_PROD_W-1:0] tagProduct;

    assign rspValid   = rsp.valid;
    assign rspTag     = rsp.tag;
    assign rspProduct = rsp.product;
    assign expTag     = sentTags[rspIdx];  // Head of the sent-tag FIFO
    assign tagProduct = expProd[expTag];

    mulTop DUT (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .inCredit (inCredit),
        .rsp      (rsp),
        .outCredit(outCredit)
    );

    always #10 clk = ~clk;

    function automatic logic [`MUL_OP_W-1:0] lcgNext(input logic [`MUL_OP_W-1:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [`MUL_OP_W-1:0] cornerValue(input int i);
        case (i)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hFFFF_FFFF;
            default: return 32'h8000_0000;
        endcase
    endfunction

    function automatic logic [`MUL_PROD_W-1:0] refProduct(input logic [`MUL_OP_W-1:0] a,
                                                          input logic [`MUL_OP_W-1:0] b);
        logic [`MUL_PROD_W-1:0] wa;
        logic [`MUL_PROD_W-1:0] wb;
        wa = {{(`MUL_PROD_W - `MUL_OP_W){1'b0}}, a};
        wb = {{(`MUL_PROD_W - `MUL_OP_W){1'b0}}, b};
        return wa * wb;
    endfunction

    // First 16 requests walk every pair of corner operands
    task automatic pickOperands(input int n, output logic [`MUL_OP_W-1:0] a,
                                output logic [`MUL_OP_W-1:0] b);
        if (n < 16) begin
            a = cornerValue(n / 4);
            b = cornerValue(n % 4);
        end else begin
            lcgState = lcgNext(lcgState);
            a = lcgState;
            lcgState = lcgNext(lcgState);
            b = lcgState;
            if (n % 7 == 3) begin
                a = cornerValue(n % 4);
            end
        end
    endtask

    task automatic sendRequest(input logic [`MUL_OP_W-1:0] a, input logic [`MUL_OP_W-1:0] b);
        while (upCredits == 0) begin
            @(posedge clk);
            #1;
        end
        req.valid = 1'b1;
        req.tag   = nextTag;
        req.op1   = a;
        req.op2   = b;
        expProd[nextTag]    = refProduct(a, b);
        sentTags[sentCount] = nextTag;
        sentCount++;
        nextTag++;
        @(posedge clk);
        #1;
        req.valid = 1'b0;
    endtask

    task automatic waitDrained();
        while (rspIdx != sentCount) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    // Credit and response bookkeeping on both sides of the DUT
    always @(posedge clk) begin
        if (rst) begin
            upCredits   = Depth;
            downCredits = OutCrd;
        end else begin
            if (req.valid) upCredits--;
            if (inCredit) upCredits++;
            if (outCredit) downCredits++;
            if (rspValid) begin
                downCredits--;
                rspIdx++;
                if (holding) heldRsp++;
            end
        end
    end

    // Downstream consumer hands back a credit whenever its counter is short
    always @(posedge clk) begin
        #1;
        outCredit = giveCredits && !rst && (downCredits < OutCrd);
    end

    resetQuiet: assert property (@(posedge clk) $past(rst) |-> !rspValid && !inCredit)
        else begin
            errCount++;
            $display("%0t: response or credit return active during or right after reset", $time);
        end

    tagOrder: assert property (@(posedge clk) disable iff (rst) rspValid |-> rspTag == expTag)
        else begin
            errCount++;
            $display("[FAIL] %0t rsp.tag expected %h actual %h",
                     $time, $sampled(expTag), $sampled(rspTag));
        end

    productOk: assert property (@(posedge clk) disable iff (rst)
        rspValid |-> rspProduct == tagProduct)
        else begin
            errCount++;
            $display("[FAIL] %0t rsp.product expected %h actual %h",
                     $time, $sampled(tagProduct), $sampled(rspProduct));
        end

    creditGate: assert property (@(posedge clk) disable iff (rst)
        rspValid |-> downCredits > 0)
        else begin
            errCount++;
            $display("%0t: response sent with no downstream credit left", $time);
        end

    heldStop: assert property (@(posedge clk) disable iff (rst)
        holding && heldRsp >= OutCrd |-> !rspValid)
        else begin
            errCount++;
            $display("%0t: response sent after the held credits ran out", $time);
        end

    creditReturn: assert property (@(posedge clk) disable iff (rst)
        inCredit == $past(rspValid))
        else begin
            errCount++;
            $display("[FAIL] %0t inCredit expected %b actual %b",
                     $time, $past(rspValid), $sampled(inCredit));
        end

    holdCount: assert property (@(posedge clk) holdEnd |-> heldRsp == OutCrd)
        else begin
            errCount++;
            $display("[FAIL] %0t heldRsp expected %0d actual %0d", $time, OutCrd, heldRsp);
        end

    upStall: assert property (@(posedge clk) holdEnd |-> upCredits == 0)
        else begin
            errCount++;
            $display("[FAIL] %0t upCredits expected 0 actual %0d", $time, upCredits);
        end

    drainCredits: assert property (@(posedge clk) drained |-> upCredits == Depth)
        else begin
            errCount++;
            $display("[FAIL] %0t upCredits expected %0d actual %0d", $time, Depth, upCredits);
        end

    drainCount: assert property (@(posedge clk) drained |-> rspIdx == NumReq)
        else begin
            errCount++;
            $display("[FAIL] %0t rspIdx expected %0d actual %0d", $time, NumReq, rspIdx);
        end

    initial begin
        #(TimeoutNs);
        $display("Timeout: run still busy after %0d ns with %0d of %0d responses",
                 TimeoutNs, rspIdx, NumReq);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        logic [`MUL_OP_W-1:0] a;
        logic [`MUL_OP_W-1:0] b;
        rst       = 1'b1;
        req       = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int n = 0; n < FreeReq; n++) begin
            pickOperands(n, a, b);
            sendRequest(a, b);
        end
        waitDrained();
        @(negedge clk);
        giveCredits = 1'b0;
        holding     = 1'b1;
        @(posedge clk);
        #1;
        fork
            for (int n = FreeReq; n < NumReq; n++) begin
                pickOperands(n, a, b);
                sendRequest(a, b);
            end
            begin
                while (upCredits != 0) begin
                    @(posedge clk);
                    #1;
                end
                repeat (10) @(posedge clk);  // Nothing may leave while the queue sits full
                @(negedge clk);
                holdEnd = 1'b1;
                @(negedge clk);
                holdEnd     = 1'b0;
                holding     = 1'b0;
                giveCredits = 1'b1;
            end
        join
        waitDrained();
        @(negedge clk);
        drained = 1'b1;
        @(negedge clk);
        drained = 1'b0;
        repeat (2) @(posedge clk);
        $display("Requests: %0d, responses: %0d, errors: %0d", sentCount, rspIdx, errCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog/mulTop.sv
module mulTop (
    input  logic            clk,
    input  logic            rst,
    input  mulPkg::mulReq_t req,
    output logic            inCredit,
    output mulPkg::mulRsp_t rsp,
    input  logic            outCredit
);

    mulPkg::ppRows_t ppRows;
    mulPkg::csPair_t csPair;
    mulPkg::mulRsp_t product;

    ppGenStage ppGen (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rows(ppRows)
    );

    // Carry-save tree down to one sum and one carry row
    wallaceReduceStage wallace (
        .clk (clk),
        .rst (rst),
        .rows(ppRows),
        .pair(csPair)
    );

    finalAddStage finalAdd (
        .clk (clk),
        .rst (rst),
        .pair(csPair),
        .prod(product)
    );

    resultQueue queue (
        .clk      (clk),
        .rst      (rst),
        .push     (product),
        .outCredit(outCredit),
        .rsp      (rsp),
        .inCredit (inCredit)
    );

endmodule

//--- verilog/resultQueue.sv
`include "mul_defines.svh"

module resultQueue (
    input  logic            clk,
    input  logic            rst,
    input  mulPkg::mulRsp_t push,
    input  logic            outCredit,
    output mulPkg::mulRsp_t rsp,
    output logic            inCredit
);

    localparam int Depth   = `MUL_QUEUE_DEPTH;
    localparam int Credits = `MUL_OUT_CREDITS;
    localparam int PtrW    = $clog2(Depth);
    localparam int CntW    = $clog2(Depth + 1);
    localparam int CrdW    = $clog2(Credits + 1);

    mulPkg::mulRsp_t mem [Depth];

    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic [CrdW-1:0] credits;  // Downstream credits on hand
    logic            pop;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
        return (p == PtrW'(Depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop = (count != '0) && (credits != '0);

    // Head entry is offered and taken in the same cycle
    assign rsp.valid   = pop;
    assign rsp.tag     = mem[rdPtr].tag;
    assign rsp.product = mem[rdPtr].product;

    always_ff @(posedge clk) begin
        if (push.valid) begin
            mem[wrPtr] <= push;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            credits  <= CrdW'(Credits);
            inCredit <= 1'b0;
        end else begin
            if (push.valid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count    <= count + CntW'(push.valid) - CntW'(pop);
            credits  <= credits + CrdW'(outCredit) - CrdW'(pop);
            inCredit <= pop;  // Freed slot goes back upstream next cycle
        end
    end

    // A push into a full queue means upstream sent without a credit
    noOverflow: assert property (@(posedge clk) disable iff (rst)
        push.valid |-> count != CntW'(Depth));

    creditMax: assert property (@(posedge clk) disable iff (rst)
        credits <= CrdW'(Credits));

endmodule

//--- verilog/finalAddStage.sv
`include "mul_defines.svh"

module finalAddStage (
    input  logic            clk,
    input  logic            rst,
    input  mulPkg::csPair_t pair,
    output mulPkg::mulRsp_t prod
);

    localparam int W = `MUL_PROD_W;

    logic [W-1:0] carryShl;
    logic [W-1:0] sumNext;

    assign carryShl = {pair.carry[W-2:0], 1'b0};  // Carry weight is one bit above its sum
    assign sumNext  = pair.sum + carryShl;

    always_ff @(posedge clk) begin
        if (rst) begin
            prod.valid <= 1'b0;
        end else begin
            prod.valid <= pair.valid;
        end
        if (pair.valid) begin
            prod.tag     <= pair.tag;
            prod.product <= sumNext;
        end
    end

endmodule

//--- verilog/wallaceReduceStage.sv
`include "mul_defines.svh"

module wallaceReduceStage (
    input  logic            clk,
    input  logic            rst,
    input  mulPkg::ppRows_t rows,
    output mulPkg::csPair_t pair
);

    localparam int NumRows = `MUL_OP_W;
    localparam int W       = `MUL_PROD_W;

    function automatic int nextRows(input int n);
        return 2 * (n / 3) + n % 3;
    endfunction

    function automatic int countLevels(input int n);
        int lv;
        int r;
        lv = 0;
        r = n;
        while (r > 2) begin
            r = nextRows(r);
            lv++;
        end
        return lv;
    endfunction

    function automatic int rowsAt(input int lv);
        int r;
        r = NumRows;
        for (int k = 0; k < lv; k++) begin
            r = nextRows(r);
        end
        return r;
    endfunction

    // 3:2 carry-save compressor, carry in the upper half
    function automatic logic [2*W-1:0] csa(input logic [W-1:0] a,
                                           input logic [W-1:0] b,
                                           input logic [W-1:0] c);
        logic [W-1:0] s;
        logic [W-1:0] cy;
        s  = a ^ b ^ c;
        cy = (a & b) | (a & c) | (b & c);
        return {cy, s};
    endfunction

    localparam int Levels = countLevels(NumRows);  // 32 -> 22 -> 15 -> 10 -> 7 -> 5 -> 4 -> 3 -> 2

    logic [W-1:0] tree [Levels+1][NumRows];

    for (genvar r = 0; r < NumRows; r++) begin : gLoad
        assign tree[0][r] = rows.rows[r];
    end

    for (genvar lv = 0; lv < Levels; lv++) begin : gLevel
        localparam int N = rowsAt(lv);
        localparam int G = N / 3;
        for (genvar g = 0; g < G; g++) begin : gCsa
            logic [2*W-1:0] sc;
            assign sc = csa(tree[lv][3*g], tree[lv][3*g+1], tree[lv][3*g+2]);
            assign tree[lv+1][2*g] = sc[W-1:0];
            if (lv == Levels - 1) begin : gLast
                assign tree[lv+1][2*g+1] = sc[2*W-1:W];  // Final add stage applies the shift
            end else begin : gMid
                assign tree[lv+1][2*g+1] = {sc[2*W-2:W], 1'b0};
            end
        end
        // Rows left over from the grouping drop straight to the next level
        for (genvar k = 0; k < N % 3; k++) begin : gPass
            assign tree[lv+1][2*G+k] = tree[lv][3*G+k];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pair.valid <= 1'b0;
        end else begin
            pair.valid <= rows.valid;
        end
        if (rows.valid) begin
            pair.tag   <= rows.tag;
            pair.sum   <= tree[Levels][0];
            pair.carry <= tree[Levels][1];
        end
    end

    // Every valid pair has to carry a known tag
    tagKnown: assert property (@(posedge clk) disable iff (rst)
        pair.valid |-> !$isunknown(pair.tag));

endmodule

//--- verilog/ppGenStage.sv
`include "mul_defines.svh"

module ppGenStage (
    input  logic            clk,
    input  logic            rst,
    input  mulPkg::mulReq_t req,
    output mulPkg::ppRows_t rows
);

    localparam int OpW   = `MUL_OP_W;
    localparam int ProdW = `MUL_PROD_W;

    logic [OpW-1:0][ProdW-1:0] ppNext;
    logic [ProdW-1:0]          op1Ext;

    assign op1Ext = {{(ProdW - OpW){1'b0}}, req.op1};

    always_comb begin
        for (int i = 0; i < OpW; i++) begin
            ppNext[i] = req.op2[i] ? (op1Ext << i) : '0;  // Zero row for a clear multiplier bit
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rows.valid <= 1'b0;
        end else begin
            rows.valid <= req.valid;
        end
        if (req.valid) begin
            rows.tag  <= req.tag;
            rows.rows <= ppNext;
        end
    end

endmodule

//--- verilog/mulPkg.sv
`include "mul_defines.svh"

package mulPkg;

    typedef struct packed {
        logic                  valid;
        logic [`MUL_TAG_W-1:0] tag;
        logic [`MUL_OP_W-1:0]  op1;
        logic [`MUL_OP_W-1:0]  op2;
    } mulReq_t;

    typedef struct packed {
        logic                                    valid;
        logic [`MUL_TAG_W-1:0]                   tag;
        logic [`MUL_OP_W-1:0][`MUL_PROD_W-1:0]   rows;  // Row i is op1 << i when op2[i] is set
    } ppRows_t;

    typedef struct packed {
        logic                   valid;
        logic [`MUL_TAG_W-1:0]  tag;
        logic [`MUL_PROD_W-1:0] sum;
        logic [`MUL_PROD_W-1:0] carry;  // Still needs the shift by one
    } csPair_t;

    typedef struct packed {
        logic                   valid;
        logic [`MUL_TAG_W-1:0]  tag;
        logic [`MUL_PROD_W-1:0] product;
    } mulRsp_t;

endpackage

//--- verilog/mul_defines.svh
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// Operand and product widths of the unsigned multiplier
`define MUL_OP_W        32
`define MUL_PROD_W      64

`define MUL_TAG_W       4   // Opaque request identifier

// Also the number of credits the upstream sender starts with
`define MUL_QUEUE_DEPTH 8

`define MUL_OUT_CREDITS 4   // Downstream credits held after reset

`endif
